//--- adc_emu_pkg.sv
package adc_emu_pkg;

	// Converter datapath widths
	localparam int unsigned ADC_IN_W  = 18;
	localparam int unsigned ADC_RAW_W = 14;
	localparam int unsigned ADC_OUT_W = 16;

	// The sum register has one bit of headroom over the input stream
	localparam int unsigned SUM_W     = ADC_IN_W + 1;

	// The sum keeps its upper bits, one more than the saturated code
	localparam int unsigned TRUNC_W   = ADC_RAW_W + 1;

	// Random bits per cycle, and the widths needed to count and difference them
	localparam int unsigned RND_W     = 13;
	localparam int unsigned CNT_W     = 4;
	localparam int unsigned NOISE_W   = CNT_W + 1;

	// Noise term is scaled by this shift before it joins the sum
	localparam int unsigned NOISE_SHIFT = 3;

	// Control register widths
	localparam int unsigned OFFSET_W  = 10;
	localparam int unsigned STRIDE_W  = 8;

	// APB bus widths
	localparam int unsigned APB_AW    = 4;
	localparam int unsigned APB_DW    = 32;

	// Bit positions inside REG_CTRL
	localparam int unsigned CTRL_NOISE_BIT  = 0;
	localparam int unsigned CTRL_RESEED_BIT = 1;

	// Values loaded by reset
	localparam logic [APB_DW-1:0]   SEED_RESET   = 32'h2545_f491;
	localparam logic [STRIDE_W-1:0] STRIDE_RESET = '0;

	// Register address map
	typedef enum logic [APB_AW-1:0] {
		REG_CTRL   = 4'h0,
		REG_OFFSET = 4'h4,
		REG_STRIDE = 4'h8,
		REG_SEED   = 4'hc
	} reg_addr_e;

endpackage

//--- reg_delay.sv
`timescale 1ns/1ps

module reg_delay #(
	parameter int dw  = 14,
	parameter int len = 1
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          gate,
	input  logic [dw-1:0] din,
	output logic [dw-1:0] dout
);

	// One register per delay step, stage 0 takes the input
	logic [dw-1:0] stage [len];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < len; i++) begin
				stage[i] <= '0;
			end
		end else if (gate) begin
			// The whole chain advances together, or not at all
			stage[0] <= din;
			for (int i = 1; i < len; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign dout = stage[len-1];

endmodule

//--- adc_emu_ctrl.sv
`timescale 1ns/1ps

module adc_emu_ctrl
	import adc_emu_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [APB_AW-1:0]          paddr,
	input  logic [APB_DW-1:0]          pwdata,
	output logic [APB_DW-1:0]          prdata,
	output logic                       pready,
	output logic                       noise_en,
	output logic                       seed_load,
	output logic [APB_DW-1:0]          seed,
	output logic signed [OFFSET_W-1:0] offset,
	output logic                       strobe
);

	logic [STRIDE_W-1:0] stride;
	logic [STRIDE_W-1:0] stride_cnt;
	logic                wr_en;
	logic                stride_wr;
	reg_addr_e           addr;

	// The slave never stalls, so each transfer is one setup plus one access cycle
	assign pready = 1'b1;

	// Addresses outside the map decode to no enum member and hit the default arm
	assign addr = reg_addr_e'(paddr);

	// A write commits on the edge that closes its access phase
	assign wr_en = psel & penable & pwrite;

	assign stride_wr = wr_en && (addr == REG_STRIDE);

	// Register file and the seed load pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			noise_en  <= 1'b0;
			offset    <= '0;
			stride    <= STRIDE_RESET;
			seed      <= SEED_RESET;
			seed_load <= 1'b0;
		end else begin
			// The pulse lasts one cycle unless another load command arrives
			seed_load <= 1'b0;
			if (wr_en) begin
				case (addr)
					REG_CTRL: begin
						noise_en  <= pwdata[CTRL_NOISE_BIT];
						// Reseed reuses whatever seed is already held
						seed_load <= pwdata[CTRL_RESEED_BIT];
					end
					REG_OFFSET: begin
						offset <= $signed(pwdata[OFFSET_W-1:0]);
					end
					REG_STRIDE: begin
						stride <= pwdata[STRIDE_W-1:0];
					end
					REG_SEED: begin
						seed      <= pwdata;
						seed_load <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Strobe generator, high for one cycle out of every stride+1
	// After reset the strobe stays low for one cycle and then follows stride 0
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stride_cnt <= '0;
			strobe     <= 1'b0;
		end else if (stride_wr) begin
			// A new stride restarts the period from the beginning
			stride_cnt <= '0;
			strobe     <= 1'b0;
		end else if (stride_cnt >= stride) begin
			// Compare with >= so a smaller stride cannot leave the counter stranded
			stride_cnt <= '0;
			strobe     <= 1'b1;
		end else begin
			stride_cnt <= stride_cnt + 1'b1;
			strobe     <= 1'b0;
		end
	end

	// Read data is driven during the access phase straight from the registers
	// The reseed bit is a command and always reads back as zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (addr)
				REG_CTRL: begin
					prdata[CTRL_NOISE_BIT] = noise_en;
				end
				REG_OFFSET: begin
					prdata[OFFSET_W-1:0] = offset;
				end
				REG_STRIDE: begin
					prdata[STRIDE_W-1:0] = stride;
				end
				REG_SEED: begin
					prdata = seed;
				end
				default: begin
					prdata = '0;
				end
			endcase
		end
	end

endmodule

//--- noise_prng.sv
`timescale 1ns/1ps

module noise_prng
	import adc_emu_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              noise_en,
	input  logic              seed_load,
	input  logic [APB_DW-1:0] seed,
	output logic [RND_W-1:0]  rnd
);

	logic [APB_DW-1:0] state;
	logic [APB_DW-1:0] step_a;
	logic [APB_DW-1:0] step_b;
	logic [APB_DW-1:0] next_state;
	logic [APB_DW-1:0] seed_safe;

	// Classic 32-bit xorshift with shifts of 13, 17 and 5
	always_comb begin
		step_a     = state ^ (state << 13);
		step_b     = step_a ^ (step_a >> 17);
		next_state = step_b ^ (step_b << 5);
	end

	// An all-zero state is a fixed point of xorshift, so it is never loaded
	assign seed_safe = (seed == '0) ? SEED_RESET : seed;

	// The generator steps every cycle, whether or not noise is enabled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SEED_RESET;
		end else if (seed_load) begin
			state <= seed_safe;
		end else begin
			state <= next_state;
		end
	end

	// With noise disabled the output looks like a stalled generator
	// All-zero bits give equal counts on successive cycles, so the noise term is zero
	assign rnd = noise_en ? state[RND_W-1:0] : '0;

endmodule

//--- adc_em.sv
`timescale 1ns/1ps

module adc_em
	import adc_emu_pkg::*;
#(
	parameter int del = 1
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        strobe,
	input  logic signed [ADC_IN_W-1:0]  in,
	input  logic        [RND_W-1:0]     rnd,
	input  logic signed [OFFSET_W-1:0]  offset,
	output logic signed [ADC_OUT_W-1:0] adc
);

	logic        [CNT_W-1:0]     ones;
	logic        [CNT_W-1:0]     ones_q;
	logic        [CNT_W-1:0]     ones_d;
	logic signed [NOISE_W-1:0]   awgn;
	logic signed [SUM_W-1:0]     sum;
	logic signed [TRUNC_W-1:0]   sum_trunc;
	logic signed [ADC_RAW_W-1:0] sat_next;
	logic signed [ADC_RAW_W-1:0] sat;
	logic        [ADC_RAW_W-1:0] dval;

	// Population count of the random bits, binomial around half of RND_W
	always_comb begin
		ones = '0;
		for (int i = 0; i < RND_W; i++) begin
			ones = ones + CNT_W'(rnd[i]);
		end
	end

	// Two successive counts are differenced, which removes the mean and gives
	// a roughly Gaussian term spanning plus and minus RND_W codes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ones_q <= '0;
			ones_d <= '0;
			awgn   <= '0;
		end else begin
			ones_q <= ones;
			ones_d <= ones_q;
			awgn   <= $signed({1'b0, ones_q}) - $signed({1'b0, ones_d});
		end
	end

	// Input, scaled noise and offset meet in one signed adder
	// The noise is shifted up so that its spread lands near one output code rms
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum <= '0;
		end else begin
			sum <= in + (awgn <<< NOISE_SHIFT) + offset;
		end
	end

	// Dropping the low four bits is a floor division by 16
	assign sum_trunc = sum[SUM_W-1 -: TRUNC_W];

	// Saturate when the two top bits disagree, keeping the sign of the sum
	always_comb begin
		if (sum_trunc[TRUNC_W-1] != sum_trunc[TRUNC_W-2]) begin
			sat_next = {sum_trunc[TRUNC_W-1], {(ADC_RAW_W-1){~sum_trunc[TRUNC_W-1]}}};
		end else begin
			sat_next = sum_trunc[ADC_RAW_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sat <= '0;
		end else begin
			sat <= sat_next;
		end
	end

	// The delay line only moves on strobe, so the stride sets the sample rate
	reg_delay #(
		.dw  (ADC_RAW_W),
		.len (del)
	) u_delay (
		.clk   (clk),
		.rst_n (rst_n),
		.gate  (strobe),
		.din   (sat),
		.dout  (dval)
	);

	// The code is left-justified in the wider output word
	assign adc = {dval, {(ADC_OUT_W-ADC_RAW_W){1'b0}}};

endmodule

//--- adc_emu_top.sv
`timescale 1ns/1ps

module adc_emu_top
	import adc_emu_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic        [APB_AW-1:0]    paddr,
	input  logic        [APB_DW-1:0]    pwdata,
	output logic        [APB_DW-1:0]    prdata,
	output logic                        pready,
	input  logic signed [ADC_IN_W-1:0]  in,
	output logic signed [ADC_OUT_W-1:0] adc,
	output logic                        sample_valid
);

	logic                       noise_en;
	logic                       seed_load;
	logic [APB_DW-1:0]          seed;
	logic signed [OFFSET_W-1:0] offset;
	logic                       strobe;
	logic [RND_W-1:0]           rnd;

	// Register block on the APB port, also the source of the sample strobe
	adc_emu_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.noise_en  (noise_en),
		.seed_load (seed_load),
		.seed      (seed),
		.offset    (offset),
		.strobe    (strobe)
	);

	noise_prng u_prng (
		.clk       (clk),
		.rst_n     (rst_n),
		.noise_en  (noise_en),
		.seed_load (seed_load),
		.seed      (seed),
		.rnd       (rnd)
	);

	// Converter core with a single-stage delay line
	adc_em #(
		.del (1)
	) u_adc (
		.clk    (clk),
		.rst_n  (rst_n),
		.strobe (strobe),
		.in     (in),
		.rnd    (rnd),
		.offset (offset),
		.adc    (adc)
	);

	// Consumers sample adc whenever the delay line has taken a new value
	assign sample_valid = strobe;

endmodule

//--- tb_adc_emu.sv
`timescale 1ns/1ps

module tb_adc_emu
	import adc_emu_pkg::*;
();

	localparam int WAIT_LIMIT     = 1000;
	localparam int NOISE_SAMPLES  = 256;
	localparam int RESEED_SAMPLES = 64;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic                        psel;
	logic                        penable;
	logic                        pwrite;
	logic        [APB_AW-1:0]    paddr;
	logic        [APB_DW-1:0]    pwdata;
	logic        [APB_DW-1:0]    prdata;
	logic                        pready;
	logic signed [ADC_IN_W-1:0]  in;
	logic signed [ADC_OUT_W-1:0] adc;
	logic                        sample_valid;

	int errors    = 0;
	int checks    = 0;
	int rand_seed = 32'hb0c5_c477;
	// Input and offset currently applied to the DUT
	int cur_in    = 0;
	int cur_off   = 0;

	// 40 ns clock period
	always #20 clk = ~clk;

	adc_emu_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.in           (in),
		.adc          (adc),
		.sample_valid (sample_valid)
	);

	// Ideal converter: floor division by 16, clip to the 14-bit code range, then scale by 4
	function automatic int ideal_adc(input int v);
		int q;
		q = v / 16;
		if ((v % 16 != 0) && (v < 0)) begin
			q = q - 1;
		end
		if (q > 8191) begin
			q = 8191;
		end else if (q < -8192) begin
			q = -8192;
		end
		return q * 4;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$finish;
	endtask

	task automatic expect_equal(input string what, input int exp, input int got);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERR %0t: %s expected %0d observed %0d", $time, what, exp, got);
		end
	endtask

	// One APB transfer, a setup cycle and then an access cycle that waits for pready
	task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
		int n;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!pready && n < WAIT_LIMIT);
		if (!pready) begin
			abort_run("Timeout: pready stayed low during an APB access");
		end
		// Read data is taken mid-cycle in the access phase
		rdata = prdata;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		logic [APB_DW-1:0] ignored;
		apb_transfer(1'b1, addr, data, ignored);
	endtask

	task automatic read_reg(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
		apb_transfer(1'b0, addr, '0, data);
	endtask

	// Step to the next cycle with sample_valid high; n is the number of cycles taken
	task automatic wait_valid(output int n);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!sample_valid && n < WAIT_LIMIT);
		if (!sample_valid) begin
			abort_run("Timeout: sample_valid never went high");
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	// The pipeline is flushed after an offset change so the old input settles with it
	task automatic use_offset(input int off);
		if (off != cur_off) begin
			write_reg(REG_OFFSET, off);
			cur_off = off;
			idle(4);
		end
	endtask

	// The new value must show up exactly three cycles after the edge that drives it
	task automatic apply_exact(input string what, input int v, input int off, input int exp);
		int prev;
		use_offset(off);
		prev = ideal_adc(cur_in + cur_off);
		@(posedge clk);
		in <= v[ADC_IN_W-1:0];
		cur_in = v;
		repeat (3) @(negedge clk);
		expect_equal({what, " one cycle early"}, prev, int'(adc));
		@(negedge clk);
		expect_equal(what, exp, int'(adc));
	endtask

	task automatic noise_run(input int v, input int off, input int noise, input int bound);
		int lo;
		int hi;
		int mid;
		int n;
		int got;
		int min_v;
		int max_v;
		int total;
		lo  = ideal_adc(v + off - bound);
		hi  = ideal_adc(v + off + bound);
		mid = ideal_adc(v + off) / 4;
		use_offset(off);
		@(posedge clk);
		in <= v[ADC_IN_W-1:0];
		cur_in = v;
		write_reg(REG_CTRL, noise);
		// Two count registers, the sum, the clip and the delay line sit between noise and adc
		idle(8);
		min_v = 32767;
		max_v = -32768;
		total = 0;
		for (int i = 0; i < NOISE_SAMPLES; i++) begin
			wait_valid(n);
			got = int'(adc);
			checks++;
			if (got < lo || got > hi) begin
				errors++;
				$display("ERR %0t: noisy sample %0d expected %0d to %0d observed %0d",
					$time, i, lo, hi, got);
			end
			min_v = (got < min_v) ? got : min_v;
			max_v = (got > max_v) ? got : max_v;
			total += got / 4;
		end
		checks++;
		if (min_v == max_v) begin
			errors++;
			$display("Noisy output never changed over %0d samples", NOISE_SAMPLES);
		end
		// Mean code must be within two codes of the noise-free code
		checks++;
		if (total < (mid - 2) * NOISE_SAMPLES || total > (mid + 2) * NOISE_SAMPLES) begin
			errors++;
			$display("ERR %0t: mean code expected %0d +/- 2 observed sum %0d over %0d samples",
				$time, mid, total, NOISE_SAMPLES);
		end
		write_reg(REG_CTRL, 32'h0);
		idle(6);
	endtask

	task automatic stride_run(input int v, input int off, input int stride, input int exp);
		int n;
		use_offset(off);
		write_reg(REG_STRIDE, stride);
		// First strobe after the counter restart, then three full periods
		wait_valid(n);
		for (int k = 0; k < 3; k++) begin
			wait_valid(n);
			expect_equal("strobe period", stride + 1, n);
		end
		// Drive on the edge that consumes a strobe, then let two more strobes pass
		@(posedge clk);
		in <= v[ADC_IN_W-1:0];
		cur_in = v;
		wait_valid(n);
		wait_valid(n);
		@(negedge clk);
		expect_equal("sample after second strobe", exp, int'(adc));
		write_reg(REG_STRIDE, 32'h0);
		idle(4);
	endtask

	initial begin
		int fd;
		int code;
		int lines;
		int mode;
		int off;
		int stride;
		int noise;
		int v;
		int expv;
		int varied;
		logic [APB_DW-1:0] rd;
		logic [8*256-1:0]  junk;
		int run_a [RESEED_SAMPLES];
		int run_b [RESEED_SAMPLES];

		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		in      = '0;
		rst_n   = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		expect_equal("adc after reset", 0, int'(adc));

		// Register readback, with unmapped addresses reading as zero
		write_reg(REG_OFFSET, 32'h0000_03a5);
		read_reg(REG_OFFSET, rd);
		expect_equal("offset readback", 32'h3a5, int'(rd));
		write_reg(REG_STRIDE, 32'h0000_005a);
		read_reg(REG_STRIDE, rd);
		expect_equal("stride readback", 32'h5a, int'(rd));
		write_reg(REG_SEED, 32'h1357_9bdf);
		read_reg(REG_SEED, rd);
		expect_equal("seed readback", 32'h1357_9bdf, int'(rd));
		write_reg(REG_CTRL, 32'h1);
		read_reg(REG_CTRL, rd);
		expect_equal("noise enable readback", 1, int'(rd));
		write_reg(REG_CTRL, 32'h0);
		read_reg(REG_CTRL, rd);
		expect_equal("noise disable readback", 0, int'(rd));
		write_reg(4'h2, 32'hffff_ffff);
		read_reg(4'h2, rd);
		expect_equal("unmapped 0x2 readback", 0, int'(rd));
		read_reg(4'hd, rd);
		expect_equal("unmapped 0xd readback", 0, int'(rd));
		write_reg(REG_OFFSET, 32'h0);
		write_reg(REG_STRIDE, 32'h0);
		idle(4);

		fd = $fopen("adc_emu_golden.txt", "r");
		lines = 0;
		if (fd == 0) begin
			errors++;
			$display("Could not open adc_emu_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, "%d %d %d %d %d %d", mode, off, stride, noise, v, expv);
				if (code != 6) begin
					// Comment lines and the end of the file land here
					code = $fgets(junk, fd);
				end else begin
					lines++;
					if (mode == 2) begin
						noise_run(v, off, noise, expv);
					end else if (mode == 3) begin
						stride_run(v, off, stride, expv);
					end else begin
						apply_exact($sformatf("golden line %0d", lines), v, off, expv);
					end
				end
			end
			$fclose(fd);
		end
		if (lines == 0) begin
			errors++;
			$display("No test vectors were read from adc_emu_golden.txt");
		end

		// Random inputs with a fresh random offset every fourth vector
		for (int g = 0; g < 32; g++) begin
			if (g % 4 == 0) begin
				off = $random(rand_seed) >>> 22;
			end
			v = $random(rand_seed) >>> 14;
			apply_exact("random sample", v, off, ideal_adc(v + off));
		end

		// The same seed loaded twice must replay the same noisy sequence
		use_offset(0);
		@(posedge clk);
		in <= 18'sd2000;
		cur_in = 2000;
		write_reg(REG_CTRL, 32'h1);
		write_reg(REG_SEED, 32'h0bad_5eed);
		idle(8);
		for (int i = 0; i < RESEED_SAMPLES; i++) begin
			@(negedge clk);
			run_a[i] = int'(adc);
		end
		// Equal runs only mean something if the noise actually moved the output
		varied = 0;
		for (int i = 1; i < RESEED_SAMPLES; i++) begin
			if (run_a[i] != run_a[0]) begin
				varied = 1;
			end
		end
		checks++;
		if (varied == 0) begin
			errors++;
			$display("Noisy output never changed during the reseed run");
		end
		write_reg(REG_SEED, 32'h0bad_5eed);
		idle(8);
		for (int i = 0; i < RESEED_SAMPLES; i++) begin
			@(negedge clk);
			run_b[i] = int'(adc);
		end
		for (int i = 0; i < RESEED_SAMPLES; i++) begin
			expect_equal($sformatf("reseeded sample %0d", i), run_a[i], run_b[i]);
		end
		// The reseed command bit reloads the seed already held in the register
		write_reg(REG_CTRL, 32'h3);
		idle(8);
		for (int i = 0; i < RESEED_SAMPLES; i++) begin
			@(negedge clk);
			run_b[i] = int'(adc);
		end
		for (int i = 0; i < RESEED_SAMPLES; i++) begin
			expect_equal($sformatf("reseed command sample %0d", i), run_a[i], run_b[i]);
		end
		write_reg(REG_CTRL, 32'h0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- adc_emu_golden.txt
# mode offset stride noise in expected (mode 2 gives the noise bound instead)
# mode 0 exact, 1 saturation, 2 noise on, 3 strided; expected values are 16-bit adc words
0 0 0 0 0 0
0 0 0 0 1600 400
0 0 0 0 -1600 -400
0 25 0 0 1000 256
0 -37 0 0 1000 240
0 -37 0 0 -5 -12
0 300 0 0 -300 0
0 511 0 0 40000 10124
0 -512 0 0 -40000 -10128
0 7 0 0 8 0
0 -1 0 0 0 -4
0 100 0 0 123456 30888
0 10 0 0 131054 32764
1 0 0 0 131071 32764
1 511 0 0 131071 32764
1 200 0 0 130900 32764
1 0 0 0 -131072 -32768
1 -512 0 0 -131072 -32768
1 -100 0 0 -131000 -32768
2 0 0 1 16000 104
2 -50 0 1 -8000 104
3 0 1 0 4800 1200
3 0 3 0 3200 800
3 -16 5 0 -3216 -808

//--- all.f
adc_emu_pkg.sv
reg_delay.sv
adc_emu_ctrl.sv
noise_prng.sv
adc_em.sv
adc_emu_top.sv
tb_adc_emu.sv

//--- run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_adc_emu -f all.f -o sim_adc_emu > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/sim_adc_emu > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q 'All tests passed!' sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
